//--- Bender.yml
package:
  name: turf_udp_rdwr

sources:
  - include_dirs:
      - src
    files:
      - src/udp_stream_pkg.sv
      - src/reg_bus_pkg.sv
      - src/udp_port_filter.sv
      - src/rdwr_bus_master.sv
      - src/rdwr_packet_engine.sv
      - src/turf_udp_rdwr_top.sv
  - target: test
    include_dirs:
      - src
      - verification
    files:
      - verification/tb_turf_udp_rdwr.sv

//--- sources.f
+incdir+src
+incdir+verification
src/udp_stream_pkg.sv
src/reg_bus_pkg.sv
src/udp_port_filter.sv
src/rdwr_bus_master.sv
src/rdwr_packet_engine.sv
src/turf_udp_rdwr_top.sv
verification/tb_turf_udp_rdwr.sv

//--- src/rdwr_bus_master.sv
`timescale 1ns/1ps
`include "turf_udp_cfg.svh"

module rdwr_bus_master (
    input  logic                   aclk,
    input  logic                   reset_i,

    input  reg_bus_pkg::reg_req_t  req_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,

    output logic                   rsp_valid_o,
    output logic [`TURF_DAT_W-1:0] rsp_rdata_o,

    output logic                   en_o,
    output logic                   wr_o,
    output logic [`TURF_ADR_W-1:0] adr_o,
    output logic [`TURF_DAT_W-1:0] dat_o,
    input  logic                   ack_i,
    input  logic [`TURF_DAT_W-1:0] dat_i
);

    logic                   en_q;
    logic                   wr_q;
    logic                   rsp_valid_q;
    logic [`TURF_ADR_W-1:0] adr_q;
    logic [`TURF_DAT_W-1:0] dat_q;
    logic [`TURF_DAT_W-1:0] rdata_q;

    logic req_fire;
    logic bus_done;

    // one transaction at a time
    assign req_ready_o = ~en_q;
    assign req_fire    = req_valid_i & req_ready_o;
    assign bus_done    = en_q & ack_i;

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            en_q        <= 1'b0;
            wr_q        <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            if (req_fire) begin
                en_q <= 1'b1;
                wr_q <= req_i.wr;
            end else if (bus_done) begin
                en_q        <= 1'b0;
                wr_q        <= 1'b0;
                rsp_valid_q <= 1'b1;
            end
        end
    end

    // address and data held for the whole cycle
    always_ff @(posedge aclk) begin
        if (req_fire) begin
            adr_q <= req_i.adr;
            dat_q <= req_i.wdata;
        end
        if (bus_done) begin
            rdata_q <= dat_i;
        end
    end

    assign en_o        = en_q;
    assign wr_o        = wr_q;
    assign adr_o       = adr_q;
    assign dat_o       = dat_q;
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rdata_q;

endmodule

//--- src/rdwr_packet_engine.sv
`timescale 1ns/1ps
`include "turf_udp_cfg.svh"

module rdwr_packet_engine (
    input  logic                      aclk,
    input  logic                      reset_i,

    input  udp_stream_pkg::udp_hdr_t  s_hdr_i,
    input  logic                      s_hdr_valid_i,
    output logic                      s_hdr_ready_o,
    input  logic                      s_is_read_i,

    input  udp_stream_pkg::udp_data_t s_data_i,
    input  logic                      s_data_valid_i,
    output logic                      s_data_ready_o,

    output udp_stream_pkg::udp_hdr_t  m_hdr_o,
    output logic                      m_hdr_valid_o,
    input  logic                      m_hdr_ready_i,

    output udp_stream_pkg::udp_data_t m_data_o,
    output logic                      m_data_valid_o,
    input  logic                      m_data_ready_i,

    output reg_bus_pkg::reg_req_t     req_o,
    output logic                      req_valid_o,
    input  logic                      req_ready_i,

    input  logic                      rsp_valid_i,
    input  logic [`TURF_DAT_W-1:0]    rsp_rdata_i
);

    typedef enum logic [2:0] {
        ST_HDR,
        ST_RHDR,
        ST_QWORD,
        ST_REQ,
        ST_WAIT,
        ST_RPLY
    } state_t;

    state_t state_q;

    // header word of the packet being served
    logic [`TURF_PAYLOAD_W-1:0] hdr_q;
    logic                       is_read_q;

    // current request qword, turned into the reply in place
    reg_bus_pkg::rw_qword_t     qword_q;
    logic                       last_q;

    logic [`TURF_PORT_W-1:0]    reply_port;

    assign reply_port = is_read_q ? `TURF_TR_PORT : `TURF_TW_PORT;

    // handshakes straight from the state
    assign s_hdr_ready_o  = state_q == ST_HDR;
    assign m_hdr_valid_o  = state_q == ST_RHDR;
    assign s_data_ready_o = state_q == ST_QWORD;
    assign req_valid_o    = state_q == ST_REQ;
    assign m_data_valid_o = state_q == ST_RPLY;

    assign m_hdr_o = '{hdr: hdr_q, port: reply_port};

    // reads never drive the write flag
    assign req_o = '{wr: ~is_read_q, adr: qword_q.adr, wdata: qword_q.wdata};

    assign m_data_o = '{data: qword_q, last: last_q};

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q <= ST_HDR;
        end else begin
            unique case (state_q)
                ST_HDR: begin
                    if (s_hdr_valid_i) begin
                        state_q <= ST_RHDR;
                    end
                end
                // reply header goes out before any reply data
                ST_RHDR: begin
                    if (m_hdr_ready_i) begin
                        state_q <= ST_QWORD;
                    end
                end
                ST_QWORD: begin
                    if (s_data_valid_i) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (req_ready_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rsp_valid_i) begin
                        state_q <= ST_RPLY;
                    end
                end
                // next qword only once this reply beat is gone
                ST_RPLY: begin
                    if (m_data_ready_i) begin
                        state_q <= last_q ? ST_HDR : ST_QWORD;
                    end
                end
                default: begin
                    state_q <= ST_HDR;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state_q == ST_HDR && s_hdr_valid_i) begin
            hdr_q     <= s_hdr_i.hdr;
            is_read_q <= s_is_read_i;
        end
        if (state_q == ST_QWORD && s_data_valid_i) begin
            qword_q <= s_data_i.data;
            last_q  <= s_data_i.last;
        end
        // read data replaces the upper half, a write is echoed as is
        if (state_q == ST_WAIT && rsp_valid_i && is_read_q) begin
            qword_q.wdata <= rsp_rdata_i;
        end
    end

endmodule

//--- src/reg_bus_pkg.sv
`include "turf_udp_cfg.svh"

package reg_bus_pkg;

    // bits between write data and address
    localparam int RSVD_W = `TURF_PAYLOAD_W - `TURF_DAT_W - `TURF_ADR_W;

    // request qword as it sits in the UDP payload
    // write data on top, address in the low bits
    typedef struct packed {
        logic [`TURF_DAT_W-1:0] wdata;
        logic [RSVD_W-1:0]      rsvd;
        logic [`TURF_ADR_W-1:0] adr;
    } rw_qword_t;

    // one register bus request
    typedef struct packed {
        logic                   wr;
        logic [`TURF_ADR_W-1:0] adr;
        logic [`TURF_DAT_W-1:0] wdata;
    } reg_req_t;

endpackage

//--- src/turf_udp_cfg.svh
`ifndef TURF_UDP_CFG_SVH
`define TURF_UDP_CFG_SVH

// stream qword width, header word is the same size
`define TURF_PAYLOAD_W 64

// UDP port number width
`define TURF_PORT_W 16

// register bus widths
`define TURF_ADR_W 28
`define TURF_DAT_W 32

// 'Tr' and 'Tw' share one window, 0x5470 to 0x5477
`define TURF_RW_PORT_BASE 16'd21616
`define TURF_RW_PORT_MASK 16'd7

// read port, also the source port of read replies
`define TURF_TR_PORT 16'd21618

// source port of write replies
`define TURF_TW_PORT 16'd21623

`endif

//--- src/turf_udp_rdwr_top.sv
`timescale 1ns/1ps
`include "turf_udp_cfg.svh"

module turf_udp_rdwr_top (
    input  logic                      aclk,
    input  logic                      reset_i,

    input  udp_stream_pkg::udp_hdr_t  s_udphdr_i,
    input  logic                      s_udphdr_valid_i,
    output logic                      s_udphdr_ready_o,

    input  udp_stream_pkg::udp_data_t s_udpdata_i,
    input  logic                      s_udpdata_valid_i,
    output logic                      s_udpdata_ready_o,

    output udp_stream_pkg::udp_hdr_t  m_udphdr_o,
    output logic                      m_udphdr_valid_o,
    input  logic                      m_udphdr_ready_i,

    output udp_stream_pkg::udp_data_t m_udpdata_o,
    output logic                      m_udpdata_valid_o,
    input  logic                      m_udpdata_ready_i,

    // register interface
    output logic                      en_o,
    output logic                      wr_o,
    output logic [`TURF_ADR_W-1:0]    adr_o,
    output logic [`TURF_DAT_W-1:0]    dat_o,
    input  logic                      ack_i,
    input  logic [`TURF_DAT_W-1:0]    dat_i
);

    // filter to engine
    udp_stream_pkg::udp_hdr_t  flt_hdr;
    logic                      flt_hdr_valid;
    logic                      flt_hdr_ready;
    logic                      flt_is_read;
    udp_stream_pkg::udp_data_t flt_data;
    logic                      flt_data_valid;
    logic                      flt_data_ready;

    // engine to bus master
    reg_bus_pkg::reg_req_t     req;
    logic                      req_valid;
    logic                      req_ready;
    logic                      rsp_valid;
    logic [`TURF_DAT_W-1:0]    rsp_rdata;

    udp_port_filter u_filter (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .s_hdr_i        (s_udphdr_i),
        .s_hdr_valid_i  (s_udphdr_valid_i),
        .s_hdr_ready_o  (s_udphdr_ready_o),
        .s_data_i       (s_udpdata_i),
        .s_data_valid_i (s_udpdata_valid_i),
        .s_data_ready_o (s_udpdata_ready_o),
        .m_hdr_o        (flt_hdr),
        .m_hdr_valid_o  (flt_hdr_valid),
        .m_hdr_ready_i  (flt_hdr_ready),
        .m_is_read_o    (flt_is_read),
        .m_data_o       (flt_data),
        .m_data_valid_o (flt_data_valid),
        .m_data_ready_i (flt_data_ready)
    );

    rdwr_packet_engine u_engine (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .s_hdr_i        (flt_hdr),
        .s_hdr_valid_i  (flt_hdr_valid),
        .s_hdr_ready_o  (flt_hdr_ready),
        .s_is_read_i    (flt_is_read),
        .s_data_i       (flt_data),
        .s_data_valid_i (flt_data_valid),
        .s_data_ready_o (flt_data_ready),
        .m_hdr_o        (m_udphdr_o),
        .m_hdr_valid_o  (m_udphdr_valid_o),
        .m_hdr_ready_i  (m_udphdr_ready_i),
        .m_data_o       (m_udpdata_o),
        .m_data_valid_o (m_udpdata_valid_o),
        .m_data_ready_i (m_udpdata_ready_i),
        .req_o          (req),
        .req_valid_o    (req_valid),
        .req_ready_i    (req_ready),
        .rsp_valid_i    (rsp_valid),
        .rsp_rdata_i    (rsp_rdata)
    );

    rdwr_bus_master u_bus_master (
        .aclk        (aclk),
        .reset_i     (reset_i),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_rdata_o (rsp_rdata),
        .en_o        (en_o),
        .wr_o        (wr_o),
        .adr_o       (adr_o),
        .dat_o       (dat_o),
        .ack_i       (ack_i),
        .dat_i       (dat_i)
    );

endmodule

//--- src/udp_port_filter.sv
`timescale 1ns/1ps
`include "turf_udp_cfg.svh"

module udp_port_filter (
    input  logic                     aclk,
    input  logic                     reset_i,

    input  udp_stream_pkg::udp_hdr_t  s_hdr_i,
    input  logic                     s_hdr_valid_i,
    output logic                     s_hdr_ready_o,

    input  udp_stream_pkg::udp_data_t s_data_i,
    input  logic                     s_data_valid_i,
    output logic                     s_data_ready_o,

    output udp_stream_pkg::udp_hdr_t  m_hdr_o,
    output logic                     m_hdr_valid_o,
    input  logic                     m_hdr_ready_i,
    output logic                     m_is_read_o,

    output udp_stream_pkg::udp_data_t m_data_o,
    output logic                     m_data_valid_o,
    input  logic                     m_data_ready_i
);

    // bits that take part in the window compare
    localparam logic [`TURF_PORT_W-1:0] WIN_MASK = ~`TURF_RW_PORT_MASK;
    localparam logic [`TURF_PORT_W-1:0] WIN_BASE = `TURF_RW_PORT_BASE & WIN_MASK;

    typedef enum logic [1:0] {
        ST_HDR,
        ST_FWD,
        ST_DRAIN
    } state_t;

    state_t state_q;
    state_t state_d;

    logic port_match;
    logic port_read;

    assign port_match = (s_hdr_i.port & WIN_MASK) == WIN_BASE;
    // only the exact 'Tr' port reads
    assign port_read  = s_hdr_i.port == `TURF_TR_PORT;

    // beats pass straight through, only the handshakes are steered
    assign m_hdr_o     = s_hdr_i;
    assign m_is_read_o = port_read;
    assign m_data_o    = s_data_i;

    always_comb begin
        state_d        = state_q;
        s_hdr_ready_o  = 1'b0;
        m_hdr_valid_o  = 1'b0;
        s_data_ready_o = 1'b0;
        m_data_valid_o = 1'b0;
        unique case (state_q)
            ST_HDR: begin
                m_hdr_valid_o = s_hdr_valid_i & port_match;
                // foreign headers are swallowed at once
                s_hdr_ready_o = port_match ? m_hdr_ready_i : 1'b1;
                if (s_hdr_valid_i && s_hdr_ready_o) begin
                    state_d = port_match ? ST_FWD : ST_DRAIN;
                end
            end
            ST_FWD: begin
                m_data_valid_o = s_data_valid_i;
                s_data_ready_o = m_data_ready_i;
                if (s_data_valid_i && m_data_ready_i && s_data_i.last) begin
                    state_d = ST_HDR;
                end
            end
            ST_DRAIN: begin
                s_data_ready_o = 1'b1;
                if (s_data_valid_i && s_data_i.last) begin
                    state_d = ST_HDR;
                end
            end
            default: begin
                state_d = ST_HDR;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q <= ST_HDR;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- src/udp_stream_pkg.sv
`include "turf_udp_cfg.svh"

package udp_stream_pkg;

    // one header beat
    // hdr is the word from the MAC core (source IP, source port, length)
    // port is the destination port inbound, the reply source port outbound
    typedef struct packed {
        logic [`TURF_PAYLOAD_W-1:0] hdr;
        logic [`TURF_PORT_W-1:0]    port;
    } udp_hdr_t;

    // one payload beat, always a full qword
    typedef struct packed {
        logic [`TURF_PAYLOAD_W-1:0] data;
        logic                       last;
    } udp_data_t;

endpackage

//--- verification/rdwr_vectors.svh
`ifndef RDWR_VECTORS_SVH
`define RDWR_VECTORS_SVH

// each row holds destination port, header word, request qwords 0 to 3,
// beat count and reply flag
// qword holds write data in [63:32], reserved bits in [31:28] and the address in [27:0]
localparam int NUM_VECTORS = 14;

localparam vec_row_t VECTORS [NUM_VECTORS] = '{
    // write and read back the same address
    '{16'd21623, 64'hC0A8_0A01_D431_0010,
      '{64'hDEAD_BEEF_0000_0010, 64'h0, 64'h0, 64'h0}, 3'd1, 1'b1},
    '{16'd21618, 64'hC0A8_0A01_D432_0010,
      '{64'hFFFF_FFFF_0000_0010, 64'h0, 64'h0, 64'h0}, 3'd1, 1'b1},
    // rest of the window writes
    '{16'd21616, 64'hC0A8_0A02_1000_0010,
      '{64'h1111_2222_0000_0021, 64'h0, 64'h0, 64'h0}, 3'd1, 1'b1},
    '{16'd21617, 64'hC0A8_0A02_1001_0010,
      '{64'h3333_4444_5ABC_DE22, 64'h0, 64'h0, 64'h0}, 3'd1, 1'b1},
    '{16'd21620, 64'hC0A8_0A03_2000_0018,
      '{64'h5555_6666_0000_0030, 64'h7777_8888_0000_0031, 64'h0, 64'h0}, 3'd2, 1'b1},
    // ports outside the window get dropped and the following packet still works
    '{16'd21601, 64'hC0A8_0A04_3000_0018,
      '{64'h0123_4567_0000_0010, 64'h89AB_CDEF_0000_0011, 64'h0, 64'h0}, 3'd2, 1'b0},
    '{16'd21618, 64'hC0A8_0A04_3001_0010,
      '{64'h0000_0000_0000_0021, 64'h0, 64'h0, 64'h0}, 3'd1, 1'b1},
    '{16'd21603, 64'hC0A8_0A05_4000_0010,
      '{64'hCAFE_F00D_0000_0021, 64'h0, 64'h0, 64'h0}, 3'd1, 1'b0},
    '{16'd21614, 64'hC0A8_0A05_4001_0020,
      '{64'hA0A0_A0A0_0000_0001, 64'hB0B0_B0B0_0000_0002,
        64'hC0C0_C0C0_0000_0003, 64'h0}, 3'd3, 1'b0},
    '{16'd12345, 64'hC0A8_0A05_4002_0010,
      '{64'hFEED_FACE_0000_0030, 64'h0, 64'h0, 64'h0}, 3'd1, 1'b0},
    // four qwords written and read back with 0xA5 never written
    '{16'd21622, 64'h0A00_0001_ABCD_0028,
      '{64'h0102_0304_0000_0040, 64'h0506_0708_1000_0041,
        64'h090A_0B0C_0000_0042, 64'h0D0E_0F10_F000_0043}, 3'd4, 1'b1},
    '{16'd21618, 64'h0A00_0001_ABCE_0028,
      '{64'h0000_0000_0000_0040, 64'h0000_0000_0000_0022,
        64'h0000_0000_0000_0030, 64'h0000_0000_0000_00A5}, 3'd4, 1'b1},
    '{16'd21619, 64'hC0A8_0A06_5000_0020,
      '{64'h9999_AAAA_0000_0050, 64'hBBBB_CCCC_0000_0051,
        64'hDDDD_EEEE_0FFF_FFFF, 64'h0}, 3'd3, 1'b1},
    '{16'd21618, 64'hC0A8_0A06_5001_0018,
      '{64'h0000_0000_0000_0051, 64'h1234_5678_0FFF_FFFF, 64'h0, 64'h0}, 3'd2, 1'b1}
};

`endif

//--- verification/tb_turf_udp_rdwr.sv
`timescale 1ns/1ps
`include "turf_udp_cfg.svh"

module tb_turf_udp_rdwr;

    // one table row per packet with qword 0 first
    typedef struct packed {
        logic [`TURF_PORT_W-1:0]         port;
        logic [`TURF_PAYLOAD_W-1:0]      hdr;
        logic [0:3][`TURF_PAYLOAD_W-1:0] qw;
        logic [2:0]                      beats;
        logic                            reply;
    } vec_row_t;

    `include "rdwr_vectors.svh"

    logic                      aclk = 1'b0;
    logic                      reset_i = 1'b1;
    udp_stream_pkg::udp_hdr_t  s_udphdr_i = '0;
    logic                      s_udphdr_valid_i = 1'b0;
    logic                      s_udphdr_ready_o;
    udp_stream_pkg::udp_data_t s_udpdata_i = '0;
    logic                      s_udpdata_valid_i = 1'b0;
    logic                      s_udpdata_ready_o;
    udp_stream_pkg::udp_hdr_t  m_udphdr_o;
    logic                      m_udphdr_valid_o;
    logic                      m_udphdr_ready_i = 1'b0;
    udp_stream_pkg::udp_data_t m_udpdata_o;
    logic                      m_udpdata_valid_o;
    logic                      m_udpdata_ready_i = 1'b0;
    logic                      en_o;
    logic                      wr_o;
    logic [`TURF_ADR_W-1:0]    adr_o;
    logic [`TURF_DAT_W-1:0]    dat_o;
    logic                      ack_i = 1'b0;
    logic [`TURF_DAT_W-1:0]    dat_i = '0;

    // expected traffic in order of arrival
    udp_stream_pkg::udp_hdr_t  exp_hdr_q[$];
    udp_stream_pkg::udp_data_t exp_data_q[$];
    reg_bus_pkg::reg_req_t     exp_bus_q[$];
    udp_stream_pkg::udp_hdr_t  hdr_exp;
    udp_stream_pkg::udp_data_t data_exp;
    reg_bus_pkg::reg_req_t     bus_exp;

    // bus side memory and the copy used for predicting reads
    logic [`TURF_DAT_W-1:0] bus_mem [256];
    logic [`TURF_DAT_W-1:0] ref_mem [256];

    logic [31:0] lcg_state = 32'd54905;
    int          ack_wait = 0;
    int          cycle_cnt = 0;
    int          cycle_limit;

    turf_udp_rdwr_top i_turf_udp_rdwr_top (.*);

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [`TURF_DAT_W-1:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5A, 8'hC3};
    endfunction

    function automatic int count_beats();
        int n;
        n = 0;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            n += VECTORS[i].beats;
        end
        return n;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic value_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        abort_run($sformatf("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                            $time, name, got, exp));
    endtask

    // queue the expected reply and bus cycles before driving the packet
    task automatic send_packet(input vec_row_t row);
        logic                       is_read;
        logic [`TURF_PAYLOAD_W-1:0] qw;
        udp_stream_pkg::udp_hdr_t   hdr_in;
        udp_stream_pkg::udp_data_t  beat;
        reg_bus_pkg::reg_req_t      txn;
        is_read     = row.port == `TURF_TR_PORT;
        hdr_in.hdr  = row.hdr;
        hdr_in.port = is_read ? `TURF_TR_PORT : `TURF_TW_PORT;
        if (row.reply) begin
            exp_hdr_q.push_back(hdr_in);
            for (int i = 0; i < row.beats; i++) begin
                qw        = row.qw[i];
                txn.wr    = !is_read;
                txn.adr   = qw[`TURF_ADR_W-1:0];
                txn.wdata = qw[`TURF_PAYLOAD_W-1 -: `TURF_DAT_W];
                exp_bus_q.push_back(txn);
                if (is_read) begin
                    beat.data = {ref_mem[qw[7:0]], qw[`TURF_DAT_W-1:0]};
                end else begin
                    beat.data = qw;
                    ref_mem[qw[7:0]] = txn.wdata;
                end
                beat.last = i == row.beats - 1;
                exp_data_q.push_back(beat);
            end
        end
        hdr_in.port = row.port;
        s_udphdr_i       <= hdr_in;
        s_udphdr_valid_i <= 1'b1;
        @(posedge aclk);
        while (!s_udphdr_ready_o) @(posedge aclk);
        s_udphdr_valid_i <= 1'b0;
        for (int i = 0; i < row.beats; i++) begin
            beat.data = row.qw[i];
            beat.last = i == row.beats - 1;
            s_udpdata_i       <= beat;
            s_udpdata_valid_i <= 1'b1;
            @(posedge aclk);
            while (!s_udpdata_ready_o) @(posedge aclk);
        end
        s_udpdata_valid_i <= 1'b0;
    endtask

    initial begin
        forever #5 aclk = ~aclk;
    end

    // register bus memory with random ack delay and random reply back-pressure
    always @(posedge aclk) begin
        if (reset_i) begin
            ack_i <= 1'b0;
        end else begin
            m_udphdr_ready_i  <= next_rand() % 4 != 0;
            m_udpdata_ready_i <= next_rand() % 4 != 0;
            if (en_o && !ack_i && ack_wait > 0) begin
                ack_wait <= ack_wait - 1;
            end else if (en_o && !ack_i) begin
                assert (exp_bus_q.size() > 0)
                    else abort_run("register bus cycle started with no request pending");
                bus_exp = exp_bus_q.pop_front();
                assert (wr_o == bus_exp.wr) else value_mismatch("wr_o", wr_o, bus_exp.wr);
                assert (adr_o == bus_exp.adr) else value_mismatch("adr_o", adr_o, bus_exp.adr);
                if (wr_o) begin
                    assert (dat_o == bus_exp.wdata)
                        else value_mismatch("dat_o", dat_o, bus_exp.wdata);
                    bus_mem[adr_o[7:0]] = dat_o;
                end
                dat_i    <= bus_mem[adr_o[7:0]];
                ack_i    <= 1'b1;
                ack_wait <= next_rand() % 4;
            end else begin
                ack_i <= 1'b0;
            end
        end
    end

    // reply checker
    always @(posedge aclk) begin
        if (!reset_i && m_udphdr_valid_o && m_udphdr_ready_i) begin
            assert (exp_hdr_q.size() > 0)
                else abort_run("reply header sent for a packet that needs no reply");
            hdr_exp = exp_hdr_q.pop_front();
            assert (m_udphdr_o.hdr == hdr_exp.hdr)
                else value_mismatch("m_udphdr_o.hdr", m_udphdr_o.hdr, hdr_exp.hdr);
            assert (m_udphdr_o.port == hdr_exp.port)
                else value_mismatch("m_udphdr_o.port", m_udphdr_o.port, hdr_exp.port);
        end
        if (!reset_i && m_udpdata_valid_o && m_udpdata_ready_i) begin
            assert (exp_data_q.size() > 0)
                else abort_run("reply data beat sent with none expected");
            data_exp = exp_data_q.pop_front();
            assert (m_udpdata_o.data == data_exp.data)
                else value_mismatch("m_udpdata_o.data", m_udpdata_o.data, data_exp.data);
            assert (m_udpdata_o.last == data_exp.last)
                else value_mismatch("m_udpdata_o.last", m_udpdata_o.last, data_exp.last);
        end
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            abort_run($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
        end
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            bus_mem[i] = fill_word(i[7:0]);
            ref_mem[i] = fill_word(i[7:0]);
        end
        cycle_limit = 40 * count_beats() + 100;
        repeat (3) @(posedge aclk);
        reset_i <= 1'b0;
        // nothing moves before the first packet
        repeat (5) begin
            @(posedge aclk);
            assert (!en_o && !wr_o && !m_udphdr_valid_o && !m_udpdata_valid_o)
                else abort_run("bus or reply output active before any packet was sent");
        end
        for (int i = 0; i < NUM_VECTORS; i++) begin
            send_packet(VECTORS[i]);
        end
        while (exp_hdr_q.size() + exp_data_q.size() + exp_bus_q.size() != 0) begin
            @(posedge aclk);
        end
        // quiet period catches stray replies or bus cycles
        repeat (20) @(posedge aclk);
        // DUT back at idle and ready for the next header
        if (s_udphdr_ready_o && !en_o && !m_udphdr_valid_o && !m_udpdata_valid_o) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("DUT not idle and ready for a header at the end of the run");
        end
    end

endmodule
